// File: dv/tb_top.sv
// Directed testbench for the AXI4-Lite register target with bus tasks, compare tasks and tests
`timescale 1ns/10ps
`default_nettype none

module tb_top
  import ocl_regmap_pkg::*;
  import tick_counter_pkg::*;
();

  localparam int unsigned TIMEOUT_CYCLES = 100;

  // Control words for the counter
  localparam ocl_data_t CTRL_ENABLE  = ocl_data_t'(1) << CTRL_ENABLE_BIT;
  localparam ocl_data_t CTRL_ONESHOT = ocl_data_t'(1) << CTRL_ONESHOT_BIT;
  localparam ocl_data_t CTRL_CLEAR   = ocl_data_t'(1) << CTRL_CLEAR_BIT;
  localparam ocl_data_t CTRL_LOAD    = ocl_data_t'(1) << CTRL_LOAD_BIT;

  logic      clk_main_a0;
  logic      rst_main_n_sync;
  logic      awvalid;
  ocl_addr_t awaddr;
  logic      awready;
  logic      wvalid;
  ocl_data_t wdata;
  logic      wready;
  logic      bvalid;
  ocl_resp_t bresp;
  logic      bready;
  logic      arvalid;
  ocl_addr_t araddr;
  logic      arready;
  logic      rvalid;
  ocl_data_t rdata;
  ocl_resp_t rresp;
  logic      rready;
  vled_t     status_vdip;
  vled_t     status_vled;

  integer seed;

  ocl_example_top u_dut (.*);

  // 10 ns clock
  initial clk_main_a0 = 1'b0;
  always #5 clk_main_a0 = ~clk_main_a0;

  // ------------------------------
  // Failure and compare tasks
  // ------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "Run stopped at first error");
  endtask

  task automatic check_data(input string name, input ocl_data_t got, input ocl_data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_vled(input string name, input vled_t got, input vled_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got 0x%04h, expected 0x%04h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input ocl_resp_t got, input ocl_resp_t exp);
    if (got !== exp) begin
      abort_run($sformatf("ERR %s: got 0x%01h, expected 0x%01h", name, got, exp));
    end
  endtask

  // One falling edge of a bounded wait
  task automatic step_wait(inout int unsigned cycles, input string what);
    @(negedge clk_main_a0);
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout while waiting for %s", what));
    end
  endtask

  // ------------------------------
  // Expected values
  // ------------------------------
  // Low half times high half, kept to 32 bits
  function automatic ocl_data_t half_product(input ocl_data_t word);
    ocl_data_t lo;
    ocl_data_t hi;
    lo = {16'h0000, word[15:0]};
    hi = {16'h0000, word[31:16]};
    return lo * hi;
  endfunction

  // Flag in bit 24, prescaler 23..16, count 15..0
  function automatic ocl_data_t expected_status(input count_t cnt, input tick_t tick,
                                                input count_t wm);
    logic ge;
    ge = (cnt >= wm);
    return {7'h00, ge, tick, cnt};
  endfunction

  // ------------------------------
  // Bus tasks
  // ------------------------------
  task automatic send_write(input ocl_addr_t addr, input ocl_data_t data);
    int unsigned cycles;
    @(negedge clk_main_a0);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    cycles  = 0;
    while (!awready) begin
      step_wait(cycles, "awready");
    end
    // Address taken at the next rising edge
    @(negedge clk_main_a0);
    awvalid = 1'b0;
    cycles  = 0;
    while (!wready) begin
      step_wait(cycles, "wready");
    end
    @(negedge clk_main_a0);
    wvalid = 1'b0;
  endtask

  task automatic wait_bvalid();
    int unsigned cycles;
    cycles = 0;
    while (!bvalid) begin
      step_wait(cycles, "bvalid");
    end
  endtask

  task automatic accept_b();
    check_resp("bresp", bresp, RESP_OKAY);
    bready = 1'b1;
    @(negedge clk_main_a0);
    bready = 1'b0;
  endtask

  task automatic bus_write(input ocl_addr_t addr, input ocl_data_t data);
    send_write(addr, data);
    wait_bvalid();
    accept_b();
  endtask

  task automatic send_read(input ocl_addr_t addr);
    int unsigned cycles;
    @(negedge clk_main_a0);
    arvalid = 1'b1;
    araddr  = addr;
    cycles  = 0;
    while (!arready) begin
      step_wait(cycles, "arready");
    end
    @(negedge clk_main_a0);
    arvalid = 1'b0;
  endtask

  task automatic wait_rvalid();
    int unsigned cycles;
    cycles = 0;
    while (!rvalid) begin
      step_wait(cycles, "rvalid");
    end
  endtask

  task automatic accept_r(output ocl_data_t data);
    data = rdata;
    check_resp("rresp", rresp, RESP_OKAY);
    rready = 1'b1;
    @(negedge clk_main_a0);
    rready = 1'b0;
  endtask

  task automatic bus_read(input ocl_addr_t addr, output ocl_data_t data);
    send_read(addr);
    wait_rvalid();
    accept_r(data);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset_defaults();
    ocl_data_t rd;
    if (!awready || !arready) begin
      abort_run("Address ready signals are not high after reset");
    end
    if (wready || bvalid || rvalid) begin
      abort_run("wready, bvalid or rvalid is high after reset");
    end
    check_vled("status_vled", status_vled, 16'h0000);
    bus_read(32'h0000_0600, rd);
    check_data("rdata", rd, UNIMPL_VALUE);
    bus_read(32'h0000_0000, rd);
    check_data("rdata", rd, UNIMPL_VALUE);
    bus_read(EXAMPLE_REG_ADDR, rd);
    check_data("rdata", rd, 32'h0000_0000);
    bus_read(CNT_STATUS_ADDR, rd);
    check_data("status", rd, expected_status(16'h0000, 8'h00, 16'h0000));
  endtask

  task automatic test_example_reg();
    ocl_data_t data;
    ocl_data_t rd;
    repeat (4) begin
      data = $random(seed);
      bus_write(EXAMPLE_REG_ADDR, data);
      bus_read(EXAMPLE_REG_ADDR, rd);
      check_data("rdata", rd, half_product(data));
    end
    // Largest product
    bus_write(EXAMPLE_REG_ADDR, 32'hFFFF_FFFF);
    bus_read(EXAMPLE_REG_ADDR, rd);
    check_data("rdata", rd, half_product(32'hFFFF_FFFF));
  endtask

  task automatic test_vled_path();
    ocl_data_t data;
    ocl_data_t rd;
    vled_t     mask;
    data = $random(seed);
    bus_write(EXAMPLE_REG_ADDR, data);
    bus_read(VLED_REG_ADDR, rd);
    check_data("vled readback", rd, {16'h0000, data[15:0]});
    repeat (2) begin
      mask = vled_t'($random(seed));
      @(negedge clk_main_a0);
      status_vdip = mask;
      // Two sync flops then the output register
      repeat (3) @(negedge clk_main_a0);
      check_vled("status_vled", status_vled, data[15:0] & mask);
    end
    data = $random(seed);
    bus_write(EXAMPLE_REG_ADDR, data);
    // Shadow register then output register, one more edge to go
    @(negedge clk_main_a0);
    check_vled("status_vled", status_vled, data[15:0] & mask);
  endtask

  task automatic test_counter_basic();
    ocl_data_t rd;
    ocl_data_t rd2;
    count_t    v;
    v = count_t'($random(seed));
    bus_write(CNT_CTRL_ADDR, CTRL_CLEAR);
    bus_read(CNT_STATUS_ADDR, rd);
    check_data("status", rd, expected_status(16'h0000, 8'h00, 16'h0000));
    bus_write(CNT_LOAD_ADDR, {16'h0000, v});
    bus_write(CNT_CTRL_ADDR, CTRL_LOAD);
    bus_read(CNT_LOAD_ADDR, rd);
    check_data("load readback", rd, {16'h0000, v});
    bus_read(CNT_STATUS_ADDR, rd);
    check_data("status", rd, expected_status(v, 8'h00, 16'h0000));
    bus_write(CNT_CTRL_ADDR, CTRL_CLEAR);
    bus_read(CNT_STATUS_ADDR, rd);
    check_data("status", rd, expected_status(16'h0000, 8'h00, 16'h0000));
    // Disabled counter holds the loaded value
    bus_write(CNT_CTRL_ADDR, CTRL_LOAD);
    bus_read(CNT_STATUS_ADDR, rd);
    bus_read(CNT_STATUS_ADDR, rd2);
    check_data("status", rd, expected_status(v, 8'h00, 16'h0000));
    check_data("status", rd2, expected_status(v, 8'h00, 16'h0000));
    // Prescaler limit zero, so one step per cycle
    bus_write(CNT_TICK_ADDR, 32'h0000_0000);
    bus_write(CNT_CTRL_ADDR, CTRL_CLEAR);
    bus_write(CNT_CTRL_ADDR, CTRL_ENABLE);
    bus_read(CNT_STATUS_ADDR, rd);
    bus_read(CNT_STATUS_ADDR, rd2);
    if (rd2[15:0] <= rd[15:0]) begin
      abort_run("Count did not advance with the counter enabled");
    end
    bus_write(CNT_CTRL_ADDR, 32'h0000_0000);
  endtask

  task automatic test_oneshot_watermark();
    ocl_data_t rd;
    count_t    v;
    count_t    wm;
    bus_write(CNT_LOAD_ADDR, {16'h0000, COUNT_MAX});
    bus_write(CNT_CTRL_ADDR, CTRL_ENABLE | CTRL_ONESHOT | CTRL_LOAD);
    bus_read(CNT_CTRL_ADDR, rd);
    check_data("ctrl readback", rd, CTRL_ENABLE | CTRL_ONESHOT);
    repeat (3) begin
      bus_read(CNT_STATUS_ADDR, rd);
      check_data("status", rd, expected_status(COUNT_MAX, 8'h00, 16'h0000));
    end
    // Value kept clear of both ends
    v = {1'b0, 15'($random(seed))} | 16'h0010;
    bus_write(CNT_CTRL_ADDR, 32'h0000_0000);
    bus_write(CNT_CTRL_ADDR, CTRL_CLEAR);
    bus_write(CNT_LOAD_ADDR, {16'h0000, v});
    bus_write(CNT_CTRL_ADDR, CTRL_LOAD);
    for (int i = 0; i < 3; i++) begin
      wm = (i == 0) ? v + 16'd5 : (i == 1) ? v - 16'd5 : v;
      bus_write(CNT_WMARK_ADDR, {16'h0000, wm});
      bus_read(CNT_STATUS_ADDR, rd);
      check_data("status", rd, expected_status(v, 8'h00, wm));
    end
  endtask

  task automatic test_back_pressure();
    ocl_data_t data;
    ocl_data_t expected;
    ocl_data_t rd;
    data     = $random(seed);
    expected = half_product(data);
    send_write(EXAMPLE_REG_ADDR, data);
    wait_bvalid();
    repeat (5) begin
      @(negedge clk_main_a0);
      if (!bvalid) begin
        abort_run("bvalid dropped before bready");
      end
      check_resp("bresp", bresp, RESP_OKAY);
    end
    accept_b();
    send_read(EXAMPLE_REG_ADDR);
    wait_rvalid();
    check_data("rdata", rdata, expected);
    repeat (5) begin
      @(negedge clk_main_a0);
      if (!rvalid) begin
        abort_run("rvalid dropped before rready");
      end
      check_data("rdata", rdata, expected);
    end
    accept_r(rd);
    check_data("rdata", rd, expected);
    // Next transfer after the stall
    bus_write(EXAMPLE_REG_ADDR, ~data);
    bus_read(EXAMPLE_REG_ADDR, rd);
    check_data("rdata", rd, half_product(~data));
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    seed            = 32'hb566_a955;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    status_vdip     = '0;
    // Reset over two rising edges
    repeat (2) @(negedge clk_main_a0);
    rst_main_n_sync = 1'b1;
    @(negedge clk_main_a0);
    test_reset_defaults();
    test_example_reg();
    test_vled_path();
    test_counter_basic();
    test_oneshot_watermark();
    test_back_pressure();
    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: ocl_example_top.f
src/ocl_regmap_pkg.sv
src/tick_counter_pkg.sv
src/ocl_slave.sv
src/example_regs.sv
src/vled_status.sv
src/tick_counter.sv
src/ocl_example_top.sv
dv/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; exit status follows the simulation

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_top \
    -Mdir obj_dir -o tb_top -f ocl_example_top.f; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/tb_top; then
  echo "Simulation returned an error status"
  exit 1
fi

echo "Simulation completed"
exit 0

// File: src/example_regs.sv
// Example and counter-configuration registers with the read-data multiplexer
`timescale 1ns/10ps
`default_nettype none

module example_regs
  import ocl_regmap_pkg::*;
  import tick_counter_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  // Strobes from the bus target
  input  logic      wr_stb,
  input  ocl_addr_t wr_addr,
  input  ocl_data_t wr_data,
  input  logic      rd_stb,
  input  ocl_addr_t rd_addr,
  output ocl_data_t rd_data,
  // LED path
  output vled_t     example_low,
  input  vled_t     vled_q,
  // Counter control
  output logic      cnt_enable,
  output logic      cnt_oneshot,
  output logic      cnt_clear,
  output logic      cnt_load,
  output tick_t     tick_value,
  output count_t    load_value,
  output count_t    watermark,
  // Counter status
  input  count_t    count,
  input  tick_t     tick_count,
  input  logic      ge_watermark
);

  ocl_data_t example_q;
  ocl_data_t example_mult;
  ocl_data_t rd_word;
  logic      wr_ctrl;

  assign example_low = example_q[15:0];
  assign wr_ctrl     = wr_stb && (wr_addr == CNT_CTRL_ADDR);

  // Low half times high half, both zero-extended
  assign example_mult = {16'h0000, example_q[15:0]} * {16'h0000, example_q[31:16]};

  // ------------------------------
  // Write decode
  // ------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      example_q   <= '0;
      cnt_enable  <= 1'b0;
      cnt_oneshot <= 1'b0;
      cnt_clear   <= 1'b0;
      cnt_load    <= 1'b0;
      tick_value  <= '0;
      load_value  <= '0;
      watermark   <= '0;
    end else begin
      // Clear and load last one cycle
      cnt_clear <= wr_ctrl & wr_data[CTRL_CLEAR_BIT];
      cnt_load  <= wr_ctrl & wr_data[CTRL_LOAD_BIT];
      if (wr_ctrl) begin
        cnt_enable  <= wr_data[CTRL_ENABLE_BIT];
        cnt_oneshot <= wr_data[CTRL_ONESHOT_BIT];
      end
      if (wr_stb && (wr_addr == EXAMPLE_REG_ADDR)) begin
        example_q <= wr_data;
      end
      if (wr_stb && (wr_addr == CNT_TICK_ADDR)) begin
        tick_value <= wr_data[$bits(tick_t)-1:0];
      end
      if (wr_stb && (wr_addr == CNT_LOAD_ADDR)) begin
        load_value <= wr_data[$bits(count_t)-1:0];
      end
      if (wr_stb && (wr_addr == CNT_WMARK_ADDR)) begin
        watermark <= wr_data[$bits(count_t)-1:0];
      end
    end
  end

  // ------------------------------
  // Read multiplexer
  // ------------------------------
  always_comb begin
    rd_word = '0;
    case (rd_addr)
      EXAMPLE_REG_ADDR: rd_word = example_mult;
      VLED_REG_ADDR:    rd_word = {16'h0000, vled_q};
      CNT_CTRL_ADDR: begin
        // Strobes read back as zero
        rd_word[CTRL_ENABLE_BIT]  = cnt_enable;
        rd_word[CTRL_ONESHOT_BIT] = cnt_oneshot;
      end
      CNT_TICK_ADDR:    rd_word = {24'h00_0000, tick_value};
      CNT_LOAD_ADDR:    rd_word = {16'h0000, load_value};
      CNT_WMARK_ADDR:   rd_word = {16'h0000, watermark};
      // Watermark flag, prescaler, then count
      CNT_STATUS_ADDR:  rd_word = {7'h00, ge_watermark, tick_count, count};
      default:          rd_word = UNIMPL_VALUE;
    endcase
  end

  // Sampled one cycle after the strobe
  always_ff @(posedge clk_main_a0) begin
    if (rd_stb) begin
      rd_data <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: src/ocl_example_top.sv
// Top level joining the AXI4-Lite target, register block, LED path and counter
`timescale 1ns/10ps
`default_nettype none

module ocl_example_top
  import ocl_regmap_pkg::*;
  import tick_counter_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  input  logic      awvalid,
  input  ocl_addr_t awaddr,
  output logic      awready,
  input  logic      wvalid,
  input  ocl_data_t wdata,
  output logic      wready,
  output logic      bvalid,
  output ocl_resp_t bresp,
  input  logic      bready,
  input  logic      arvalid,
  input  ocl_addr_t araddr,
  output logic      arready,
  output logic      rvalid,
  output ocl_data_t rdata,
  output ocl_resp_t rresp,
  input  logic      rready,
  input  vled_t     status_vdip,
  output vled_t     status_vled
);

  // ------------------------------
  // Internal strobes and status
  // ------------------------------
  logic      wr_stb;
  ocl_addr_t wr_addr;
  ocl_data_t wr_data;
  logic      rd_stb;
  ocl_addr_t rd_addr;
  ocl_data_t rd_data;
  vled_t     example_low;
  vled_t     vled_q;
  logic      cnt_enable;
  logic      cnt_oneshot;
  logic      cnt_clear;
  logic      cnt_load;
  tick_t     tick_value;
  count_t    load_value;
  count_t    watermark;
  count_t    count;
  tick_t     tick_count;
  logic      ge_watermark;

  // Bus target
  ocl_slave u_ocl_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .wr_stb          (wr_stb),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_stb          (rd_stb),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // Register block
  example_regs u_example_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_stb          (wr_stb),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_stb          (rd_stb),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .example_low     (example_low),
    .vled_q          (vled_q),
    .cnt_enable      (cnt_enable),
    .cnt_oneshot     (cnt_oneshot),
    .cnt_clear       (cnt_clear),
    .cnt_load        (cnt_load),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark),
    .count           (count),
    .tick_count      (tick_count),
    .ge_watermark    (ge_watermark)
  );

  // Virtual LEDs
  vled_status u_vled_status (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .example_low     (example_low),
    .status_vdip     (status_vdip),
    .vled_q          (vled_q),
    .status_vled     (status_vled)
  );

  // Prescaled counter
  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_enable      (cnt_enable),
    .cnt_oneshot     (cnt_oneshot),
    .cnt_clear       (cnt_clear),
    .cnt_load        (cnt_load),
    .tick_value      (tick_value),
    .load_value      (load_value),
    .watermark       (watermark),
    .count           (count),
    .tick_count      (tick_count),
    .ge_watermark    (ge_watermark)
  );

endmodule

`default_nettype wire

// File: src/ocl_regmap_pkg.sv
// Bus types, register map, control-bit positions, response code and unimplemented value
`default_nettype none

package ocl_regmap_pkg;

  // ------------------------------
  // Bus types
  // ------------------------------
  typedef logic [31:0] ocl_addr_t;
  typedef logic [31:0] ocl_data_t;
  typedef logic [1:0]  ocl_resp_t;
  typedef logic [15:0] vled_t;

  // Only response ever returned
  localparam ocl_resp_t RESP_OKAY = 2'b00;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam ocl_addr_t EXAMPLE_REG_ADDR = 32'h0000_0500;
  localparam ocl_addr_t VLED_REG_ADDR    = 32'h0000_0504;
  localparam ocl_addr_t CNT_CTRL_ADDR    = 32'h0000_0510;
  localparam ocl_addr_t CNT_TICK_ADDR    = 32'h0000_0514;
  localparam ocl_addr_t CNT_LOAD_ADDR    = 32'h0000_0518;
  localparam ocl_addr_t CNT_WMARK_ADDR   = 32'h0000_051C;
  localparam ocl_addr_t CNT_STATUS_ADDR  = 32'h0000_0520;

  // Counter control word, held bits first, then self-clearing strobes
  localparam int unsigned CTRL_ENABLE_BIT  = 0;
  localparam int unsigned CTRL_ONESHOT_BIT = 1;
  localparam int unsigned CTRL_CLEAR_BIT   = 2;
  localparam int unsigned CTRL_LOAD_BIT    = 3;

  // Marker for reads outside the map
  localparam ocl_data_t UNIMPL_VALUE = 32'hDEAD_BEEF;

endpackage

`default_nettype wire

// File: src/ocl_slave.sv
// AXI4-Lite single-beat target producing internal write and read strobes
`timescale 1ns/10ps
`default_nettype none

module ocl_slave
  import ocl_regmap_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  // Write address
  input  logic      awvalid,
  input  ocl_addr_t awaddr,
  output logic      awready,
  // Write data
  input  logic      wvalid,
  input  ocl_data_t wdata,
  output logic      wready,
  // Write response
  output logic      bvalid,
  output ocl_resp_t bresp,
  input  logic      bready,
  // Read address
  input  logic      arvalid,
  input  ocl_addr_t araddr,
  output logic      arready,
  // Read data
  output logic      rvalid,
  output ocl_data_t rdata,
  output ocl_resp_t rresp,
  input  logic      rready,
  // Register block side
  output logic      wr_stb,
  output ocl_addr_t wr_addr,
  output ocl_data_t wr_data,
  output logic      rd_stb,
  output ocl_addr_t rd_addr,
  input  ocl_data_t rd_data
);

  // ------------------------------
  // Write path
  // ------------------------------
  logic      wr_active;
  ocl_addr_t wr_addr_q;

  // One write outstanding, released by the b handshake
  assign awready = ~wr_active;
  // Data accepted once per write, never while the response waits
  assign wready  = wr_active & ~bvalid & wvalid;
  assign wr_stb  = wvalid & wready;
  assign wr_addr = wr_addr_q;
  assign wr_data = wdata;
  assign bresp   = RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        wr_active <= 1'b1;
      end else if (bvalid && bready) begin
        wr_active <= 1'b0;
      end
      // Response one cycle after the data beat
      if (wr_stb) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Address capture at the aw handshake
  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr_q <= awaddr;
    end
  end

  // ------------------------------
  // Read path
  // ------------------------------
  logic      rd_pend;
  logic      rd_stb_q;
  logic      rd_fill;
  ocl_addr_t rd_addr_q;

  assign arready = ~rd_pend;
  assign rd_stb  = rd_stb_q;
  assign rd_addr = rd_addr_q;
  assign rresp   = RESP_OKAY;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rd_pend  <= 1'b0;
      rd_stb_q <= 1'b0;
      rd_fill  <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      // Strobe in the cycle after ar, data ready one cycle later
      rd_stb_q <= arvalid & arready;
      rd_fill  <= rd_stb_q;
      if (arvalid && arready) begin
        rd_pend <= 1'b1;
      end else if (rvalid && rready) begin
        rd_pend <= 1'b0;
      end
      if (rd_fill) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (arvalid && arready) begin
      rd_addr_q <= araddr;
    end
    // Read word held until the next read fills it
    if (rd_fill) begin
      rdata <= rd_data;
    end
  end

  // ------------------------------
  // Response hold checks
  // ------------------------------
  a_bvalid_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid && $stable(bresp));

  a_rvalid_hold : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

`default_nettype wire

// File: src/tick_counter.sv
// Prescaled 16-bit counter with clear, load, one-shot and watermark compare
`timescale 1ns/10ps
`default_nettype none

module tick_counter
  import tick_counter_pkg::*;
(
  input  logic   clk_main_a0,
  input  logic   rst_main_n_sync,
  input  logic   cnt_enable,
  input  logic   cnt_oneshot,
  input  logic   cnt_clear,
  input  logic   cnt_load,
  input  tick_t  tick_value,
  input  count_t load_value,
  input  count_t watermark,
  output count_t count,
  output tick_t  tick_count,
  output logic   ge_watermark
);

  logic tick_wrap;
  logic cnt_hold;

  // Prescaler reached its limit this cycle
  assign tick_wrap = cnt_enable && (tick_count >= tick_value);
  // One-shot saturates instead of wrapping
  assign cnt_hold  = cnt_oneshot && (count == COUNT_MAX);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      count        <= '0;
      tick_count   <= '0;
      ge_watermark <= 1'b0;
    end else begin
      ge_watermark <= (count >= watermark);
      // Clear wins over everything
      if (cnt_clear) begin
        tick_count <= '0;
      end else if (tick_wrap) begin
        tick_count <= '0;
      end else if (cnt_enable) begin
        tick_count <= tick_count + 1'b1;
      end
      if (cnt_clear) begin
        count <= '0;
      end else if (cnt_load) begin
        count <= load_value;
      end else if (tick_wrap && !cnt_hold) begin
        count <= count + 1'b1;
      end
    end
  end

  // ------------------------------
  // One-shot never rolls over
  // ------------------------------
  a_oneshot_sat : assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    cnt_oneshot && (count == COUNT_MAX) && !cnt_clear && !cnt_load |=> count != '0);

endmodule

`default_nettype wire

// File: src/tick_counter_pkg.sv
// Counter and prescaler widths, their types and the counter maximum
`default_nettype none

package tick_counter_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned COUNT_W = 16;
  localparam int unsigned TICK_W  = 8;

  // Main counter and prescaler values
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [TICK_W-1:0]  tick_t;

  // Saturation point in one-shot mode
  localparam count_t COUNT_MAX = '1;

endpackage

`default_nettype wire

// File: src/vled_status.sv
// DIP-switch synchronizer, LED shadow register and masked LED output
`timescale 1ns/10ps
`default_nettype none

module vled_status
  import ocl_regmap_pkg::*;
(
  input  logic  clk_main_a0,
  input  logic  rst_main_n_sync,
  input  vled_t example_low,
  input  vled_t status_vdip,
  output vled_t vled_q,
  output vled_t status_vled
);

  // Two-flop synchronizer stages
  vled_t vdip_q;
  vled_t vdip_q2;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q      <= '0;
      vdip_q2     <= '0;
      vled_q      <= '0;
      status_vled <= '0;
    end else begin
      vdip_q      <= status_vdip;
      vdip_q2     <= vdip_q;
      // LED register shadows the example low half
      vled_q      <= example_low;
      // LEDs lit only where the DIP switch is on
      status_vled <= vled_q & vdip_q2;
    end
  end

endmodule

`default_nettype wire
